//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_dram_ctrl_top \
    -f vlog.f -o sim_dram_ctrl > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_dram_ctrl > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

//--- tb/dram_model.sv
`default_nettype none

module dram_model (
    input  wire                     clk_dram_ctrl,
    input  wire                     rst_dram_ctrl,
    input  wire                     i_mem_stb,
    input  wire                     i_mem_we,
    input  wire mem_pkg::mem_addr_t i_mem_addr,
    input  wire mem_pkg::mem_data_t i_mem_wdata,
    output logic                    o_mem_stall,
    output logic                    o_mem_ack,
    output mem_pkg::mem_data_t      o_mem_rdata,
    input  wire mem_pkg::mem_addr_t i_peek_addr,
    output mem_pkg::mem_data_t      o_peek_data,
    output logic                    o_overflow
);

    localparam int STORE_DEPTH   = 16;
    localparam int ACK_DELAY_MAX = 6;

    mem_pkg::mem_data_t store [STORE_DEPTH];
    mem_pkg::mem_data_t pend_data [$];  // answers, oldest first
    longint             pend_due [$];   // cycle each answer is acked
    longint             cycle;
    longint             last_due;
    integer             seed = 32'h8ffc5145;

    assign o_peek_data = store[i_peek_addr[3:0]];

    always @(posedge clk_dram_ctrl) begin : step
        int     delay;
        longint due;
        if (rst_dram_ctrl) begin
            o_mem_stall <= 1'b0;
            o_mem_ack   <= 1'b0;
            o_mem_rdata <= '0;
            o_overflow  <= 1'b0;
            pend_data.delete();
            pend_due.delete();
            cycle    = 0;
            last_due = 0;
        end else begin
            o_mem_ack <= 1'b0;
            if (pend_due.size() != 0 && pend_due[0] == cycle) begin
                o_mem_ack   <= 1'b1;
                o_mem_rdata <= pend_data.pop_front();
                void'(pend_due.pop_front());
            end
            if (i_mem_stb && !o_mem_stall) begin
                delay = 1 + int'($unsigned($random(seed)) % ACK_DELAY_MAX);
                due   = cycle + delay;
                if (due <= last_due) due = last_due + 1;  // acks stay in order
                last_due = due;
                if (i_mem_we) begin
                    store[i_mem_addr[3:0]] = i_mem_wdata;
                    pend_data.push_back('0);
                end else begin
                    pend_data.push_back(store[i_mem_addr[3:0]]);
                end
                pend_due.push_back(due);
                if (pend_due.size() > mem_pkg::OUTSTANDING_MAX) o_overflow <= 1'b1;
            end
            o_mem_stall <= (($random(seed) & 3) == 0);  // roughly one cycle in four
            cycle = cycle + 1;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;  // released on a rising edge
    end

endmodule

`default_nettype wire

//--- tb/tb_dram_ctrl_top.sv
`default_nettype none

module tb_dram_ctrl_top;

    localparam int WAIT_LIMIT = 400;  // cycles
    localparam int LOAD_BEATS = 8;
    localparam int READS      = 24;

    wire                   clk_dram_ctrl;
    wire                   rst_dram_ctrl;
    logic                  i_wr_valid;
    mem_pkg::mem_data_t    i_wr_data;
    logic                  i_wr_last;
    logic                  i_rd_addr_valid;
    mem_pkg::mem_addr_t    i_rd_addr;
    logic                  i_audio_ready;
    panel_pkg::disp_sel_e  i_disp_sel;
    logic                  o_wr_ready;
    logic                  o_rd_addr_ready;
    logic                  o_audio_valid;
    mem_pkg::mem_data_t    o_audio_data;
    logic                  o_load_complete;
    logic [7:0]            o_ss_an;
    logic [6:0]            o_ss_c;
    logic                  mem_stb;
    logic                  mem_we;
    mem_pkg::mem_addr_t    mem_addr;
    mem_pkg::mem_data_t    mem_wdata;
    logic                  mem_stall;
    logic                  mem_ack;
    mem_pkg::mem_data_t    mem_rdata;
    mem_pkg::mem_addr_t    peek_addr;
    mem_pkg::mem_data_t    peek_data;
    logic                  model_overflow;

    mem_pkg::mem_data_t    beats [LOAD_BEATS];
    mem_pkg::mem_addr_t    read_addrs [READS];
    mem_pkg::mem_data_t    expect_q [$];  // audio data still to come
    int                    req_count;
    int                    beat_count;
    int                    errors;
    int                    tests;
    integer                seed;

    tb_clock_gen u_clk (
        .o_clk (clk_dram_ctrl),
        .o_rst (rst_dram_ctrl)
    );

    dram_ctrl_top uut (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr_valid      (i_wr_valid),
        .i_wr_data       (i_wr_data),
        .i_wr_last       (i_wr_last),
        .o_wr_ready      (o_wr_ready),
        .i_rd_addr_valid (i_rd_addr_valid),
        .i_rd_addr       (i_rd_addr),
        .o_rd_addr_ready (o_rd_addr_ready),
        .o_mem_stb       (mem_stb),
        .o_mem_we        (mem_we),
        .o_mem_addr      (mem_addr),
        .o_mem_wdata     (mem_wdata),
        .i_mem_stall     (mem_stall),
        .i_mem_ack       (mem_ack),
        .i_mem_rdata     (mem_rdata),
        .o_audio_valid   (o_audio_valid),
        .o_audio_data    (o_audio_data),
        .i_audio_ready   (i_audio_ready),
        .i_disp_sel      (i_disp_sel),
        .o_load_complete (o_load_complete),
        .o_ss_an         (o_ss_an),
        .o_ss_c          (o_ss_c)
    );

    dram_model u_dram (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_mem_stb     (mem_stb),
        .i_mem_we      (mem_we),
        .i_mem_addr    (mem_addr),
        .i_mem_wdata   (mem_wdata),
        .o_mem_stall   (mem_stall),
        .o_mem_ack     (mem_ack),
        .o_mem_rdata   (mem_rdata),
        .i_peek_addr   (peek_addr),
        .o_peek_data   (peek_data),
        .o_overflow    (model_overflow)
    );

    // active-low segments, bit 0 is a
    function automatic logic [6:0] hex_segments(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    function automatic logic [7:0] digit_mask(input int k);
        logic [7:0] m;
        m    = 8'hff;
        m[k] = 1'b0;  // one-cold
        return m;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_data(input string name, input mem_pkg::mem_data_t got,
                              input mem_pkg::mem_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input mem_pkg::mem_addr_t got,
                              input mem_pkg::mem_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input panel_pkg::disp_word_t got,
                              input panel_pkg::disp_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_seg(input string name, input logic [6:0] got, input logic [6:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    // walks all eight digits and rebuilds the shown word from the segments
    task automatic check_display(input string name, input panel_pkg::disp_word_t exp,
                                 output panel_pkg::disp_word_t shown);
        int   waited;
        logic found;
        shown = '0;
        for (int k = 0; k < panel_pkg::DIGITS; k++) begin
            waited = 0;
            @(negedge clk_dram_ctrl);
            while (o_ss_an !== digit_mask(k) && waited < WAIT_LIMIT) begin
                @(negedge clk_dram_ctrl);
                waited++;
            end
            if (o_ss_an !== digit_mask(k)) begin
                report_error($sformatf("digit %0d was never lit", k));
            end else begin
                check_seg($sformatf("o_ss_c digit %0d", k), o_ss_c, hex_segments(exp[4*k +: 4]));
                found = 1'b0;
                for (int v = 0; v < 16; v++) begin
                    if (o_ss_c === hex_segments(4'(v))) begin
                        shown[4*k +: 4] = 4'(v);
                        found = 1'b1;
                    end
                end
                if (!found) report_error($sformatf("digit %0d shows no hex digit", k));
            end
        end
        check_word(name, shown, exp);
    endtask

    task automatic test_reset();
        int                    errs_before;
        int                    waited;
        panel_pkg::disp_word_t shown;
        errs_before = errors;
        waited = 0;
        @(negedge clk_dram_ctrl);
        while (rst_dram_ctrl !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk_dram_ctrl);
            waited++;
        end
        if (rst_dram_ctrl !== 1'b0) report_error("reset was never released");
        check_bit("o_wr_ready", o_wr_ready, 1'b0);  // first cycle out of reset
        check_bit("o_mem_stb", mem_stb, 1'b0);
        check_bit("o_rd_addr_ready", o_rd_addr_ready, 1'b0);
        check_bit("o_audio_valid", o_audio_valid, 1'b0);
        check_bit("o_load_complete", o_load_complete, 1'b0);
        check_display("traffic word after reset", '0, shown);
        finish_test("reset", errs_before);
    endtask

    task automatic test_read_refused();
        int errs_before;
        errs_before = errors;
        @(posedge clk_dram_ctrl);
        i_rd_addr_valid <= 1'b1;
        i_rd_addr       <= mem_pkg::mem_addr_t'(3);
        repeat (20) begin
            @(negedge clk_dram_ctrl);
            check_bit("o_rd_addr_ready", o_rd_addr_ready, 1'b0);
        end
        @(posedge clk_dram_ctrl);
        i_rd_addr_valid <= 1'b0;
        finish_test("read refused before load", errs_before);
    endtask

    task automatic test_load();
        int errs_before;
        int waited;
        errs_before = errors;
        for (int k = 0; k < LOAD_BEATS; k++) begin
            beats[k] = {$random(seed), $random(seed), $random(seed), $random(seed)};
            @(posedge clk_dram_ctrl);
            i_wr_valid <= 1'b1;
            i_wr_data  <= beats[k];
            i_wr_last  <= (k == LOAD_BEATS - 1);
            waited = 0;
            @(negedge clk_dram_ctrl);
            while (!o_wr_ready && waited < WAIT_LIMIT) begin
                @(negedge clk_dram_ctrl);
                waited++;
            end
            if (o_wr_ready) req_count++;
            else report_error($sformatf("load beat %0d was never taken", k));
        end
        @(posedge clk_dram_ctrl);
        i_wr_valid <= 1'b0;
        i_wr_last  <= 1'b0;
        waited = 0;
        @(negedge clk_dram_ctrl);
        while (!o_load_complete && waited < WAIT_LIMIT) begin
            @(negedge clk_dram_ctrl);
            waited++;
        end
        if (!o_load_complete) report_error("load complete never rose");
        for (int k = 0; k < LOAD_BEATS; k++) begin
            @(posedge clk_dram_ctrl);
            peek_addr <= mem_pkg::mem_addr_t'(k);
            @(negedge clk_dram_ctrl);
            check_data($sformatf("dram[%0d]", k), peek_data, beats[k]);
        end
        // an extra beat must be refused
        @(posedge clk_dram_ctrl);
        i_wr_valid <= 1'b1;
        repeat (10) begin
            @(negedge clk_dram_ctrl);
            check_bit("o_wr_ready", o_wr_ready, 1'b0);
        end
        @(posedge clk_dram_ctrl);
        i_wr_valid <= 1'b0;
        finish_test("load", errs_before);
    endtask

    task automatic send_read_addresses();
        int waited;
        for (int i = 0; i < READS; i++) begin
            @(posedge clk_dram_ctrl);
            i_rd_addr_valid <= 1'b1;
            i_rd_addr       <= read_addrs[i];
            waited = 0;
            @(negedge clk_dram_ctrl);
            while (!o_rd_addr_ready && waited < WAIT_LIMIT) begin
                @(negedge clk_dram_ctrl);
                waited++;
            end
            if (o_rd_addr_ready) begin
                expect_q.push_back(beats[int'(read_addrs[i])]);
                req_count++;
            end else begin
                report_error($sformatf("read address %0d was never taken", i));
            end
        end
        @(posedge clk_dram_ctrl);
        i_rd_addr_valid <= 1'b0;
    endtask

    task automatic receive_audio();
        int got;
        int waited;
        int draw;
        got    = 0;
        waited = 0;
        while (got < READS && waited < WAIT_LIMIT) begin
            @(posedge clk_dram_ctrl);
            draw = $random(seed);
            i_audio_ready <= draw[0];  // random back-pressure
            @(negedge clk_dram_ctrl);
            if (o_audio_valid && i_audio_ready) begin
                if (expect_q.size() == 0) report_error("audio beat with no read outstanding");
                else check_data("o_audio_data", o_audio_data, expect_q.pop_front());
                beat_count++;
                got++;
                waited = 0;
            end else begin
                waited++;
            end
        end
        if (got < READS) report_error("audio stream stopped before all reads returned");
        @(posedge clk_dram_ctrl);
        i_audio_ready <= 1'b0;
    endtask

    task automatic test_readback();
        int errs_before;
        errs_before = errors;
        for (int i = 0; i < READS; i++) begin
            read_addrs[i] = mem_pkg::mem_addr_t'($unsigned($random(seed)) % LOAD_BEATS);
        end
        fork
            send_read_addresses();
            receive_audio();
        join
        check_bit("dram in-flight overflow", model_overflow, 1'b0);
        finish_test("readback", errs_before);
    endtask

    task automatic test_display();
        int                    errs_before;
        panel_pkg::disp_word_t shown;
        errs_before = errors;
        @(posedge clk_dram_ctrl);
        i_disp_sel <= panel_pkg::DISP_TRAFFIC;
        check_display("traffic word", {beat_count[15:0], req_count[15:0]}, shown);
        @(posedge clk_dram_ctrl);
        i_disp_sel <= panel_pkg::DISP_LOAD;
        check_display("load word", {7'd0, 1'b1, 24'd8}, shown);
        check_addr("shown write address", shown[23:0], mem_pkg::mem_addr_t'(8));
        @(posedge clk_dram_ctrl);
        i_disp_sel <= panel_pkg::DISP_BLANK;
        check_display("blank word", '0, shown);
        finish_test("display", errs_before);
    endtask

    initial begin
        i_wr_valid      = 1'b0;
        i_wr_data       = '0;
        i_wr_last       = 1'b0;
        i_rd_addr_valid = 1'b0;
        i_rd_addr       = '0;
        i_audio_ready   = 1'b0;
        i_disp_sel      = panel_pkg::DISP_TRAFFIC;
        peek_addr       = '0;
        req_count       = 0;
        beat_count      = 0;
        errors          = 0;
        tests           = 0;
        seed            = 32'h8ffc5145;
        test_reset();
        test_read_refused();
        test_load();
        test_readback();
        test_display();
        $display("%0d errors in %0d tests", errors, tests);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dram_ctrl_top.sv
`default_nettype none

module dram_ctrl_top (
    input  wire                       clk_dram_ctrl,
    input  wire                       rst_dram_ctrl,
    // sample load stream
    input  wire                       i_wr_valid,
    input  wire mem_pkg::mem_data_t   i_wr_data,
    input  wire                       i_wr_last,
    output logic                      o_wr_ready,
    // audio read addresses
    input  wire                       i_rd_addr_valid,
    input  wire mem_pkg::mem_addr_t   i_rd_addr,
    output logic                      o_rd_addr_ready,
    // DDR3 controller request bus
    output logic                      o_mem_stb,
    output logic                      o_mem_we,
    output mem_pkg::mem_addr_t        o_mem_addr,
    output mem_pkg::mem_data_t        o_mem_wdata,
    input  wire                       i_mem_stall,
    input  wire                       i_mem_ack,
    input  wire mem_pkg::mem_data_t   i_mem_rdata,
    // audio read data
    output logic                      o_audio_valid,
    output mem_pkg::mem_data_t        o_audio_data,
    input  wire                       i_audio_ready,
    // panel
    input  wire panel_pkg::disp_sel_e i_disp_sel,
    output logic                      o_load_complete,
    output logic [panel_pkg::DIGITS-1:0] o_ss_an,
    output logic [6:0]                o_ss_c
);

    logic                  accept;
    mem_pkg::mem_op_e      accept_op;
    logic                  req_room;
    logic                  read_room;
    mem_pkg::mem_addr_t    write_addr;
    panel_pkg::disp_word_t disp_word;

    request_arbiter u_arb (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr_valid      (i_wr_valid),
        .i_wr_data       (i_wr_data),
        .i_wr_last       (i_wr_last),
        .i_rd_addr_valid (i_rd_addr_valid),
        .i_rd_addr       (i_rd_addr),
        .i_mem_stall     (i_mem_stall),
        .i_req_room      (req_room),
        .i_read_room     (read_room),
        .o_wr_ready      (o_wr_ready),
        .o_rd_addr_ready (o_rd_addr_ready),
        .o_mem_stb       (o_mem_stb),
        .o_mem_we        (o_mem_we),
        .o_mem_addr      (o_mem_addr),
        .o_mem_wdata     (o_mem_wdata),
        .o_accept        (accept),
        .o_accept_op     (accept_op),
        .o_write_addr    (write_addr),
        .o_load_complete (o_load_complete)
    );

    read_return_buffer u_ret (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_accept      (accept),
        .i_accept_op   (accept_op),
        .i_mem_ack     (i_mem_ack),
        .i_mem_rdata   (i_mem_rdata),
        .i_audio_ready (i_audio_ready),
        .o_req_room    (req_room),
        .o_read_room   (read_room),
        .o_audio_valid (o_audio_valid),
        .o_audio_data  (o_audio_data)
    );

    status_display u_status (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_mem_ack       (i_mem_ack),
        .i_audio_valid   (o_audio_valid),
        .i_audio_ready   (i_audio_ready),
        .i_write_addr    (write_addr),
        .i_load_complete (o_load_complete),
        .i_disp_sel      (i_disp_sel),
        .o_disp_word     (disp_word)
    );

    seven_segment_controller u_ssc (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_disp_word   (disp_word),
        .o_ss_an       (o_ss_an),
        .o_ss_c        (o_ss_c)
    );

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // controller request bus
    localparam int ADDR_W = 24;   // burst address
    localparam int DATA_W = 128;  // one burst

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] mem_data_t;

    // we bit on the request bus
    typedef enum logic {
        MEM_OP_READ  = 1'b0,
        MEM_OP_WRITE = 1'b1
    } mem_op_e;

    // both depths are powers of two, pointers wrap on their own
    localparam int OUTSTANDING_MAX = 4;
    localparam int RETURN_DEPTH    = 4;

    localparam int OP_PTR_W  = $clog2(OUTSTANDING_MAX);
    localparam int OP_CNT_W  = $clog2(OUTSTANDING_MAX + 1);
    localparam int RET_PTR_W = $clog2(RETURN_DEPTH);
    localparam int RET_CNT_W = $clog2(RETURN_DEPTH + 1);

    typedef logic [OP_PTR_W-1:0]  op_ptr_t;
    typedef logic [OP_CNT_W-1:0]  op_cnt_t;
    typedef logic [RET_PTR_W-1:0] ret_ptr_t;
    typedef logic [RET_CNT_W-1:0] ret_cnt_t;

    // sample load first, then audio reads only
    typedef enum logic {
        ARB_LOAD = 1'b0,
        ARB_RUN  = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

//--- verilog/panel_pkg.sv
`default_nettype none

package panel_pkg;

    localparam int DIGITS       = 8;
    localparam int DIGIT_PERIOD = 16;  // cycles per lit digit

    localparam int DIGIT_W = $clog2(DIGITS);
    localparam int DWELL_W = $clog2(DIGIT_PERIOD);

    typedef logic [4*DIGITS-1:0] disp_word_t;  // eight hex nibbles
    typedef logic [15:0]         count_t;      // wraps
    typedef logic [DIGIT_W-1:0]  digit_t;
    typedef logic [DWELL_W-1:0]  dwell_t;

    // code 3 is unused and shows zero like DISP_BLANK
    typedef enum logic [1:0] {
        DISP_TRAFFIC = 2'd0,
        DISP_LOAD    = 2'd1,
        DISP_BLANK   = 2'd2
    } disp_sel_e;

endpackage

`default_nettype wire

//--- verilog/read_return_buffer.sv
`default_nettype none

module read_return_buffer (
    input  wire                     clk_dram_ctrl,
    input  wire                     rst_dram_ctrl,
    input  wire                     i_accept,
    input  wire mem_pkg::mem_op_e   i_accept_op,
    input  wire                     i_mem_ack,
    input  wire mem_pkg::mem_data_t i_mem_rdata,
    input  wire                     i_audio_ready,
    output logic                    o_req_room,
    output logic                    o_read_room,
    output logic                    o_audio_valid,
    output mem_pkg::mem_data_t      o_audio_data
);

    // opcodes of requests in flight, oldest at op_rd_ptr
    mem_pkg::mem_op_e   op_mem [mem_pkg::OUTSTANDING_MAX];
    mem_pkg::op_ptr_t   op_wr_ptr;
    mem_pkg::op_ptr_t   op_rd_ptr;
    mem_pkg::op_cnt_t   op_count;
    mem_pkg::op_cnt_t   reads_inflight;

    mem_pkg::mem_data_t ret_mem [mem_pkg::RETURN_DEPTH];
    mem_pkg::ret_ptr_t  ret_wr_ptr;
    mem_pkg::ret_ptr_t  ret_rd_ptr;
    mem_pkg::ret_cnt_t  ret_count;

    logic ack_read;  // ack belongs to a read
    logic acc_read;
    logic ret_pop;

    assign ack_read = i_mem_ack && (op_mem[op_rd_ptr] == mem_pkg::MEM_OP_READ);
    assign acc_read = i_accept && (i_accept_op == mem_pkg::MEM_OP_READ);
    assign ret_pop  = o_audio_valid && i_audio_ready;

    assign o_req_room  = op_count < mem_pkg::op_cnt_t'(mem_pkg::OUTSTANDING_MAX);
    // credit covers data still coming back plus data waiting here
    assign o_read_room = (int'(reads_inflight) + int'(ret_count)) < mem_pkg::RETURN_DEPTH;

    assign o_audio_valid = (ret_count != '0);
    assign o_audio_data  = ret_mem[ret_rd_ptr];

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            op_wr_ptr      <= '0;
            op_rd_ptr      <= '0;
            op_count       <= '0;
            reads_inflight <= '0;
            ret_wr_ptr     <= '0;
            ret_rd_ptr     <= '0;
            ret_count      <= '0;
        end else begin
            if (i_accept) op_wr_ptr <= op_wr_ptr + 1'b1;
            if (i_mem_ack) op_rd_ptr <= op_rd_ptr + 1'b1;
            case ({i_accept, i_mem_ack})
                2'b10:   op_count <= op_count + 1'b1;
                2'b01:   op_count <= op_count - 1'b1;
                default: ;
            endcase
            case ({acc_read, ack_read})
                2'b10:   reads_inflight <= reads_inflight + 1'b1;
                2'b01:   reads_inflight <= reads_inflight - 1'b1;
                default: ;
            endcase
            if (ack_read) ret_wr_ptr <= ret_wr_ptr + 1'b1;
            if (ret_pop) ret_rd_ptr <= ret_rd_ptr + 1'b1;
            case ({ack_read, ret_pop})
                2'b10:   ret_count <= ret_count + 1'b1;
                2'b01:   ret_count <= ret_count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (i_accept) op_mem[op_wr_ptr] <= i_accept_op;
        if (ack_read) ret_mem[ret_wr_ptr] <= i_mem_rdata;
    end

    // acks are in order, so each one must match a queued request
    a_ack_has_req : assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_mem_ack |-> (op_count != '0)
    );

    a_ret_no_overflow : assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (ack_read && !ret_pop) |-> (ret_count < mem_pkg::ret_cnt_t'(mem_pkg::RETURN_DEPTH))
    );

endmodule

`default_nettype wire

//--- verilog/request_arbiter.sv
`default_nettype none

module request_arbiter (
    input  wire                 clk_dram_ctrl,
    input  wire                 rst_dram_ctrl,
    input  wire                 i_wr_valid,
    input  wire mem_pkg::mem_data_t i_wr_data,
    input  wire                 i_wr_last,
    input  wire                 i_rd_addr_valid,
    input  wire mem_pkg::mem_addr_t i_rd_addr,
    input  wire                 i_mem_stall,
    input  wire                 i_req_room,
    input  wire                 i_read_room,
    output logic                o_wr_ready,
    output logic                o_rd_addr_ready,
    output logic                o_mem_stb,
    output logic                o_mem_we,
    output mem_pkg::mem_addr_t  o_mem_addr,
    output mem_pkg::mem_data_t  o_mem_wdata,
    output logic                o_accept,
    output mem_pkg::mem_op_e    o_accept_op,
    output mem_pkg::mem_addr_t  o_write_addr,
    output logic                o_load_complete
);

    mem_pkg::arb_state_e state;
    logic                armed;       // holds ready low one cycle out of reset
    logic                slot_full;
    logic                slot_open;
    mem_pkg::mem_op_e    slot_op;
    mem_pkg::mem_addr_t  slot_addr;
    mem_pkg::mem_data_t  slot_data;
    logic                slot_last;   // slot holds the final load beat
    mem_pkg::mem_addr_t  write_addr;
    logic                wr_take;
    logic                rd_take;

    assign slot_open = armed && !slot_full;

    // a write also needs room in the outstanding queue
    assign o_wr_ready      = slot_open && i_req_room && (state == mem_pkg::ARB_LOAD);
    assign o_rd_addr_ready = slot_open && i_req_room && i_read_room
                             && (state == mem_pkg::ARB_RUN);

    assign wr_take = i_wr_valid && o_wr_ready;
    assign rd_take = i_rd_addr_valid && o_rd_addr_ready;

    // slot goes straight onto the bus
    assign o_mem_stb   = slot_full;
    assign o_mem_we    = (slot_op == mem_pkg::MEM_OP_WRITE);
    assign o_mem_addr  = slot_addr;
    assign o_mem_wdata = slot_data;

    assign o_accept        = slot_full && !i_mem_stall;
    assign o_accept_op     = slot_op;
    assign o_write_addr    = write_addr;
    assign o_load_complete = (state == mem_pkg::ARB_RUN);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state      <= mem_pkg::ARB_LOAD;
            armed      <= 1'b0;
            slot_full  <= 1'b0;
            write_addr <= '0;
        end else begin
            armed <= 1'b1;
            if (wr_take || rd_take) begin
                slot_full <= 1'b1;
            end else if (o_accept) begin
                slot_full <= 1'b0;  // ready again next cycle
                if (slot_op == mem_pkg::MEM_OP_WRITE) begin
                    write_addr <= write_addr + 1'b1;
                    if (slot_last) begin
                        state <= mem_pkg::ARB_RUN;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (wr_take) begin
            slot_op   <= mem_pkg::MEM_OP_WRITE;
            slot_addr <= write_addr;  // bursts land at 0, 1, 2, ...
            slot_data <= i_wr_data;
            slot_last <= i_wr_last;
        end else if (rd_take) begin
            slot_op   <= mem_pkg::MEM_OP_READ;
            slot_addr <= i_rd_addr;
            slot_last <= 1'b0;
        end
    end

    // controller sees a steady request until it takes it
    a_stall_stable : assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (o_mem_stb && i_mem_stall) |=> (o_mem_stb && $stable(o_mem_we)
            && $stable(o_mem_addr) && $stable(o_mem_wdata))
    );

    // no write reaches the bus once the sample load is done
    a_no_write_after_load : assert property (
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_load_complete |-> !(o_mem_stb && o_mem_we)
    );

endmodule

`default_nettype wire

//--- verilog/seven_segment_controller.sv
`default_nettype none

module seven_segment_controller (
    input  wire                        clk_dram_ctrl,
    input  wire                        rst_dram_ctrl,
    input  wire panel_pkg::disp_word_t i_disp_word,
    output logic [panel_pkg::DIGITS-1:0] o_ss_an,
    output logic [6:0]                 o_ss_c
);

    panel_pkg::dwell_t dwell;
    panel_pkg::digit_t digit_idx;
    logic [3:0]        nibble;
    logic [6:0]        seg;  // bit 0 is a, bit 6 is g, active high
    logic [panel_pkg::DIGITS-1:0] digit_sel;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            dwell     <= '0;
            digit_idx <= '0;
        end else if (dwell == panel_pkg::dwell_t'(panel_pkg::DIGIT_PERIOD - 1)) begin
            dwell <= '0;
            if (digit_idx == panel_pkg::digit_t'(panel_pkg::DIGITS - 1)) digit_idx <= '0;
            else digit_idx <= digit_idx + 1'b1;
        end else begin
            dwell <= dwell + 1'b1;
        end
    end

    assign nibble = i_disp_word[{digit_idx, 2'b00} +: 4];

    always_comb begin
        digit_sel            = '0;
        digit_sel[digit_idx] = 1'b1;
    end

    always_comb begin
        case (nibble)
            4'h0: seg = 7'h3f;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5b;
            4'h3: seg = 7'h4f;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6d;
            4'h6: seg = 7'h7d;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7f;
            4'h9: seg = 7'h6f;
            4'ha: seg = 7'h77;
            4'hb: seg = 7'h7c;  // lower case b
            4'hc: seg = 7'h39;
            4'hd: seg = 7'h5e;  // lower case d
            4'he: seg = 7'h79;
            default: seg = 7'h71;
        endcase
    end

    // anodes and cathodes both pull low
    assign o_ss_an = ~digit_sel;
    assign o_ss_c  = ~seg;

endmodule

`default_nettype wire

//--- verilog/status_display.sv
`default_nettype none

module status_display (
    input  wire                      clk_dram_ctrl,
    input  wire                      rst_dram_ctrl,
    input  wire                      i_mem_ack,
    input  wire                      i_audio_valid,
    input  wire                      i_audio_ready,
    input  wire mem_pkg::mem_addr_t  i_write_addr,
    input  wire                      i_load_complete,
    input  wire panel_pkg::disp_sel_e i_disp_sel,
    output panel_pkg::disp_word_t    o_disp_word
);

    panel_pkg::count_t ack_count;   // completed requests
    panel_pkg::count_t beat_count;  // audio beats taken downstream

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            ack_count  <= '0;
            beat_count <= '0;
        end else begin
            if (i_mem_ack) begin
                ack_count <= ack_count + 1'b1;
            end
            if (i_audio_valid && i_audio_ready) begin
                beat_count <= beat_count + 1'b1;
            end
        end
    end

    always_comb begin
        case (i_disp_sel)
            panel_pkg::DISP_TRAFFIC: begin
                o_disp_word = {beat_count, ack_count};
            end
            panel_pkg::DISP_LOAD: begin
                // flag on bit 24, address below it
                o_disp_word = {7'd0, i_load_complete, i_write_addr};
            end
            default: begin
                o_disp_word = '0;  // blank and the spare code
            end
        endcase
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/mem_pkg.sv
verilog/panel_pkg.sv
verilog/request_arbiter.sv
verilog/read_return_buffer.sv
verilog/status_display.sv
verilog/seven_segment_controller.sv
verilog/dram_ctrl_top.sv
tb/tb_clock_gen.sv
tb/dram_model.sv
tb/tb_dram_ctrl_top.sv
